// File: common/snake_config.svh
// Snake game configuration
`ifndef SNAKE_CONFIG_SVH
`define SNAKE_CONFIG_SVH

// main_clk cycles per game tick
`define GAME_TICK_DIV 10_000_000

// keyboard make codes
`define KEY_START  8'h1B
`define KEY_ESC    8'h76
`define KEY_PAUSE  8'h4D
`define KEY_RESUME 8'h2D
`define KEY_UP     8'h75
`define KEY_DOWN   8'h72
`define KEY_RIGHT  8'h74
`define KEY_LEFT   8'h6B

// segments in the ring
`define SNAKE_LEN 4

// rows of the idle and start poses
`define IDLE_ROW  48
`define START_ROW 23

// ticks during which turns are ignored after a turn
`define TURN_LOCK_TICKS 3

`endif

// File: common/snake_pkg.sv
// Snake game shared types
package snake_pkg;

    // one grid coordinate, wraps at 64
    typedef logic [5:0] coord_t;

    // slot index into the segment ring
    typedef logic [1:0] seg_idx_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } segment_t;

    // slot 0 sits in the low bits
    typedef segment_t [3:0] body_t;

    typedef enum logic [3:0] {
        cmd_none   = 4'd0,
        cmd_start  = 4'd1,
        cmd_escape = 4'd2,
        cmd_pause  = 4'd3,
        cmd_resume = 4'd4,
        cmd_up     = 4'd5,
        cmd_down   = 4'd6,
        cmd_left   = 4'd7,
        cmd_right  = 4'd8
    } key_cmd_t;

    typedef enum logic [1:0] {
        mode_idle   = 2'd0,
        mode_moving = 2'd1,
        mode_paused = 2'd2,
        mode_blank  = 2'd3
    } game_mode_t;

    typedef enum logic [1:0] {
        dir_up    = 2'd0,
        dir_down  = 2'd1,
        dir_left  = 2'd2,
        dir_right = 2'd3
    } dir_t;

    typedef enum logic [1:0] {
        op_hold       = 2'd0,
        op_load_start = 2'd1,
        op_move       = 2'd2
    } body_op_t;

endpackage

// File: design/game_tick_gen.sv
// Game tick generator
`timescale 1ns/1ps
`include "snake_config.svh"

module game_tick_gen #(
    parameter int tick_div = `GAME_TICK_DIV
) (
    input  logic main_clk,
    input  logic rst_n,
    output logic tick
);

    localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge main_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= cnt_w'(tick_div - 1);
        end else if (cnt == '0) begin
            cnt <= cnt_w'(tick_div - 1); // reload for next period
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // one-cycle enable in place of a divided clock
    assign tick = (cnt == '0);

endmodule

// File: design/key_decoder.sv
// Keyboard command decoder
`timescale 1ns/1ps
`include "snake_config.svh"

module key_decoder (
    input  logic                main_clk,
    input  logic                rst_n,
    input  logic [7:0]          key_code,
    input  logic                key_valid,
    input  logic                tick,
    output snake_pkg::key_cmd_t cmd
);

    snake_pkg::key_cmd_t key_cmd;
    snake_pkg::key_cmd_t pending;
    logic                key_hit;
    logic                key_take;

    function automatic snake_pkg::key_cmd_t decode(input logic [7:0] code);
        case (code)
            `KEY_START:  decode = snake_pkg::cmd_start;
            `KEY_ESC:    decode = snake_pkg::cmd_escape;
            `KEY_PAUSE:  decode = snake_pkg::cmd_pause;
            `KEY_RESUME: decode = snake_pkg::cmd_resume;
            `KEY_UP:     decode = snake_pkg::cmd_up;
            `KEY_DOWN:   decode = snake_pkg::cmd_down;
            `KEY_LEFT:   decode = snake_pkg::cmd_left;
            `KEY_RIGHT:  decode = snake_pkg::cmd_right;
            default:     decode = snake_pkg::cmd_none;
        endcase
    endfunction

    assign key_cmd = decode(key_code);
    assign key_hit = key_valid && (key_cmd != snake_pkg::cmd_none);

    // escape and start only yield to each other
    always_comb begin
        case (pending)
            snake_pkg::cmd_escape: key_take = (key_cmd == snake_pkg::cmd_start);
            snake_pkg::cmd_start:  key_take = (key_cmd == snake_pkg::cmd_escape);
            default:               key_take = 1'b1;
        endcase
    end

    always_ff @(posedge main_clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= snake_pkg::cmd_none;
        end else if (tick) begin
            pending <= key_hit ? key_cmd : snake_pkg::cmd_none; // consumed this tick
        end else if (key_hit && key_take) begin
            pending <= key_cmd;
        end
    end

    assign cmd = pending;

endmodule

// File: game_fsm/game_fsm.sv
// Game mode and direction FSM
`timescale 1ns/1ps
`include "snake_config.svh"

module game_fsm (
    input  logic                  main_clk,
    input  logic                  rst_n,
    input  logic                  tick,
    input  snake_pkg::key_cmd_t   cmd,
    output snake_pkg::game_mode_t mode,
    output snake_pkg::dir_t       dir,
    output snake_pkg::body_op_t   op,
    output logic                  all_black
);

    snake_pkg::game_mode_t mode_q;
    snake_pkg::game_mode_t mode_d;
    snake_pkg::dir_t       dir_q;
    snake_pkg::dir_t       dir_d;
    snake_pkg::dir_t       cmd_dir;
    logic [1:0]            lock_q;
    logic [1:0]            lock_d;
    logic                  cmd_arrow;
    logic                  turn_ok;

    function automatic logic is_vert(input snake_pkg::dir_t d);
        return (d == snake_pkg::dir_up) || (d == snake_pkg::dir_down);
    endfunction

    // arrow command to direction, with arrow flag
    always_comb begin
        cmd_arrow = 1'b1;
        case (cmd)
            snake_pkg::cmd_up:    cmd_dir = snake_pkg::dir_up;
            snake_pkg::cmd_down:  cmd_dir = snake_pkg::dir_down;
            snake_pkg::cmd_left:  cmd_dir = snake_pkg::dir_left;
            snake_pkg::cmd_right: cmd_dir = snake_pkg::dir_right;
            default: begin
                cmd_dir   = dir_q;
                cmd_arrow = 1'b0;
            end
        endcase
    end

    // perpendicular only, and not while locked out
    assign turn_ok = cmd_arrow && (is_vert(cmd_dir) != is_vert(dir_q)) && (lock_q == 2'd0);

    always_comb begin
        mode_d = mode_q;
        dir_d  = dir_q;
        lock_d = lock_q;
        op     = snake_pkg::op_hold;
        if (tick) begin
            if (cmd == snake_pkg::cmd_escape) begin
                mode_d = snake_pkg::mode_blank; // body frozen
            end else if (cmd == snake_pkg::cmd_start) begin
                op     = snake_pkg::op_load_start;
                mode_d = snake_pkg::mode_moving;
                dir_d  = snake_pkg::dir_right;
                lock_d = 2'd0;
            end else begin
                case (mode_q)
                    snake_pkg::mode_paused: begin
                        if (cmd == snake_pkg::cmd_resume) begin
                            mode_d = snake_pkg::mode_moving;
                            op     = snake_pkg::op_move; // moves on the resume tick
                        end
                    end
                    snake_pkg::mode_moving: begin
                        if (cmd == snake_pkg::cmd_pause) begin
                            mode_d = snake_pkg::mode_paused;
                        end else if (turn_ok) begin
                            dir_d  = cmd_dir;
                            op     = snake_pkg::op_move;
                            lock_d = 2'(`TURN_LOCK_TICKS);
                        end else begin
                            op = snake_pkg::op_move;
                            if (lock_q != 2'd0) begin
                                lock_d = lock_q - 2'd1;
                            end
                        end
                    end
                    default: begin
                        // idle and blank wait for start or escape
                    end
                endcase
            end
        end
    end

    always_ff @(posedge main_clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= snake_pkg::mode_idle;
            dir_q  <= snake_pkg::dir_right;
            lock_q <= 2'd0;
        end else begin
            mode_q <= mode_d;
            dir_q  <= dir_d;
            lock_q <= lock_d;
        end
    end

    assign mode      = mode_q;
    assign dir       = dir_d; // new direction applies on the turn tick
    assign all_black = (mode_q == snake_pkg::mode_blank);

endmodule

// File: snake_body/snake_body.sv
// Snake segment ring
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_body (
    input  logic                main_clk,
    input  logic                rst_n,
    input  snake_pkg::body_op_t op,
    input  snake_pkg::dir_t     dir,
    output snake_pkg::body_t    body
);

    snake_pkg::body_t    body_q;
    snake_pkg::seg_idx_t head_q;
    snake_pkg::seg_idx_t tail_q;
    snake_pkg::segment_t head_seg;
    snake_pkg::segment_t next_seg;

    // straight row, slot i at x = i
    function automatic snake_pkg::body_t pose(input snake_pkg::coord_t row);
        snake_pkg::body_t b;
        for (int i = 0; i < `SNAKE_LEN; i++) begin
            b[i].x = snake_pkg::coord_t'(i);
            b[i].y = row;
        end
        return b;
    endfunction

    function automatic snake_pkg::segment_t step(
        input snake_pkg::segment_t s,
        input snake_pkg::dir_t     d
    );
        snake_pkg::segment_t n;
        n = s;
        case (d)
            snake_pkg::dir_right: n.x = s.x + 6'd1; // wraps at 64
            snake_pkg::dir_left:  n.x = s.x - 6'd1;
            snake_pkg::dir_down:  n.y = s.y + 6'd1;
            default:              n.y = s.y - 6'd1;
        endcase
        return n;
    endfunction

    assign head_seg = body_q[head_q];
    assign next_seg = step(head_seg, dir);

    always_ff @(posedge main_clk or negedge rst_n) begin
        if (!rst_n) begin
            body_q <= pose(snake_pkg::coord_t'(`IDLE_ROW));
            head_q <= snake_pkg::seg_idx_t'(`SNAKE_LEN - 1);
            tail_q <= '0;
        end else begin
            case (op)
                snake_pkg::op_load_start: begin
                    body_q <= pose(snake_pkg::coord_t'(`START_ROW));
                    head_q <= snake_pkg::seg_idx_t'(`SNAKE_LEN - 1);
                    tail_q <= '0;
                end
                snake_pkg::op_move: begin
                    body_q[tail_q] <= next_seg; // new head over old tail
                    head_q         <= tail_q;
                    tail_q         <= tail_q + 2'd1;
                end
                default: begin
                    // hold
                end
            endcase
        end
    end

    assign body = body_q;

endmodule

// File: design/snake_game_top.sv
// Snake game controller top
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_game_top #(
    parameter int tick_div = `GAME_TICK_DIV
) (
    input  logic                  main_clk,
    input  logic                  rst_n,
    input  logic [7:0]            key_code,
    input  logic                  key_valid,
    output logic                  tick,
    output snake_pkg::game_mode_t mode,
    output logic                  all_black,
    output snake_pkg::body_t      body
);

    snake_pkg::key_cmd_t cmd;
    snake_pkg::body_op_t op;
    snake_pkg::dir_t     dir;

    game_tick_gen #(
        .tick_div (tick_div)
    ) u_tick_gen (
        .main_clk (main_clk),
        .rst_n    (rst_n),
        .tick     (tick)
    );

    key_decoder u_key_decoder (
        .main_clk  (main_clk),
        .rst_n     (rst_n),
        .key_code  (key_code),
        .key_valid (key_valid),
        .tick      (tick),
        .cmd       (cmd)
    );

    game_fsm u_game_fsm (
        .main_clk  (main_clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .cmd       (cmd),
        .mode      (mode),
        .dir       (dir),
        .op        (op),
        .all_black (all_black)
    );

    snake_body u_snake_body (
        .main_clk (main_clk),
        .rst_n    (rst_n),
        .op       (op),
        .dir      (dir),
        .body     (body)
    );

endmodule

// File: tests/snake_game_tb.sv
// Snake game controller testbench
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_game_tb;

    localparam int tick_div     = 16;
    localparam int tick_timeout = 64;
    localparam int num_rows     = 23;

    localparam snake_pkg::game_mode_t m_idle  = snake_pkg::mode_idle;
    localparam snake_pkg::game_mode_t m_move  = snake_pkg::mode_moving;
    localparam snake_pkg::game_mode_t m_pause = snake_pkg::mode_paused;
    localparam snake_pkg::game_mode_t m_blank = snake_pkg::mode_blank;

    typedef struct packed {
        logic [7:0]            key0;
        logic [7:0]            key1;
        logic [3:0]            ticks;
        logic                  load;  // start pose loaded on the first tick
        logic [3:0]            moves; // move steps after any load
        snake_pkg::game_mode_t mode;
        logic                  all_black;
        snake_pkg::coord_t     head_x;
        snake_pkg::coord_t     head_y;
        snake_pkg::coord_t     tail_x;
        snake_pkg::coord_t     tail_y;
    } row_t;

    logic                  main_clk;
    logic                  rst_n;
    logic [7:0]            key_code;
    logic                  key_valid;
    logic                  tick;
    snake_pkg::game_mode_t mode;
    logic                  all_black;
    snake_pkg::body_t      body;

    row_t                tbl [num_rows];
    integer              seed;
    snake_pkg::seg_idx_t head_ptr;
    snake_pkg::seg_idx_t tail_ptr;
    int                  pass_cnt;
    int                  fail_cnt;

    snake_game_top #(
        .tick_div (tick_div)
    ) dut (
        .main_clk  (main_clk),
        .rst_n     (rst_n),
        .key_code  (key_code),
        .key_valid (key_valid),
        .tick      (tick),
        .mode      (mode),
        .all_black (all_black),
        .body      (body)
    );

    always #4 main_clk = ~main_clk;

    function automatic row_t make_row(
        input logic [7:0] k0, input logic [7:0] k1, input int ticks, input bit load,
        input int moves, input snake_pkg::game_mode_t m, input bit blk,
        input int hx, input int hy, input int tx, input int ty
    );
        row_t r;
        r.key0      = k0;
        r.key1      = k1;
        r.ticks     = 4'(ticks);
        r.load      = load;
        r.moves     = 4'(moves);
        r.mode      = m;
        r.all_black = blk;
        r.head_x    = 6'(hx);
        r.head_y    = 6'(hy);
        r.tail_x    = 6'(tx);
        r.tail_y    = 6'(ty);
        return r;
    endfunction

    // hand-derived expected head and tail after each row
    task automatic fill_table();
        tbl[0]  = make_row(8'h00, 8'h00, 3, 0, 0, m_idle, 0, 3, 48, 0, 48);
        tbl[1]  = make_row(`KEY_START, 8'h00, 1, 1, 0, m_move, 0, 3, 23, 0, 23);
        tbl[2]  = make_row(8'h00, 8'h00, 2, 0, 2, m_move, 0, 5, 23, 2, 23);
        // up accepted, then left locked out for three ticks
        tbl[3]  = make_row(`KEY_UP, 8'h00, 1, 0, 1, m_move, 0, 5, 22, 3, 23);
        tbl[4]  = make_row(`KEY_LEFT, 8'h00, 1, 0, 1, m_move, 0, 5, 21, 4, 23);
        tbl[5]  = make_row(`KEY_LEFT, 8'h00, 1, 0, 1, m_move, 0, 5, 20, 5, 23);
        tbl[6]  = make_row(`KEY_LEFT, 8'h00, 1, 0, 1, m_move, 0, 5, 19, 5, 22);
        tbl[7]  = make_row(`KEY_LEFT, 8'h00, 1, 0, 1, m_move, 0, 4, 19, 5, 21);
        tbl[8]  = make_row(8'h00, 8'h00, 3, 0, 3, m_move, 0, 1, 19, 4, 19);
        tbl[9]  = make_row(`KEY_RIGHT, 8'h00, 1, 0, 1, m_move, 0, 0, 19, 3, 19); // reverse
        // pause, arrows while paused, resume wraps x to 63
        tbl[10] = make_row(`KEY_PAUSE, 8'h00, 1, 0, 0, m_pause, 0, 0, 19, 3, 19);
        tbl[11] = make_row(`KEY_UP, `KEY_DOWN, 2, 0, 0, m_pause, 0, 0, 19, 3, 19);
        tbl[12] = make_row(`KEY_RESUME, 8'h00, 1, 0, 1, m_move, 0, 63, 19, 2, 19);
        tbl[13] = make_row(`KEY_ESC, 8'h00, 1, 0, 0, m_blank, 1, 63, 19, 2, 19);
        tbl[14] = make_row(`KEY_RIGHT, 8'h00, 2, 0, 0, m_blank, 1, 63, 19, 2, 19);
        tbl[15] = make_row(`KEY_START, 8'h00, 2, 1, 1, m_move, 0, 4, 23, 1, 23);
        tbl[16] = make_row(`KEY_ESC, `KEY_LEFT, 1, 0, 0, m_blank, 1, 4, 23, 1, 23);
        // long run left from the start pose
        tbl[17] = make_row(`KEY_START, 8'h00, 1, 1, 0, m_move, 0, 3, 23, 0, 23);
        tbl[18] = make_row(`KEY_UP, 8'h00, 1, 0, 1, m_move, 0, 3, 22, 1, 23);
        tbl[19] = make_row(8'h00, 8'h00, 3, 0, 3, m_move, 0, 3, 19, 3, 22);
        tbl[20] = make_row(`KEY_LEFT, 8'h00, 1, 0, 1, m_move, 0, 2, 19, 3, 21);
        tbl[21] = make_row(8'h00, 8'h00, 3, 0, 3, m_move, 0, 63, 19, 2, 19);
        tbl[22] = make_row(8'h00, 8'h00, 2, 0, 2, m_move, 0, 61, 19, 0, 19);
    endtask

    function automatic logic is_key(input logic [7:0] code);
        case (code)
            `KEY_START, `KEY_ESC, `KEY_PAUSE, `KEY_RESUME,
            `KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT: is_key = 1'b1;
            default: is_key = 1'b0;
        endcase
    endfunction

    // called on a falling edge, returns one falling edge later
    task automatic send_key(input logic [7:0] code);
        key_code  = code;
        key_valid = 1'b1;
        @(negedge main_clk);
        key_code  = 8'h00;
        key_valid = 1'b0;
    endtask

    task automatic send_filler();
        logic [7:0] code;
        code = $random(seed);
        while (is_key(code)) begin
            code = $random(seed);
        end
        send_key(code);
    endtask

    // returns on the falling edge after the tick cycle
    task automatic wait_tick(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < tick_timeout) begin
            @(negedge main_clk);
            n++;
            if (tick) begin
                ok = 1'b1;
            end
        end
        if (ok) begin
            @(negedge main_clk);
        end
    endtask

    // ring pointers follow the move rule
    task automatic track_ptrs(input row_t e);
        if (e.load) begin
            head_ptr = snake_pkg::seg_idx_t'(`SNAKE_LEN - 1);
            tail_ptr = '0;
        end
        for (int i = 0; i < e.moves; i++) begin
            head_ptr = tail_ptr;
            tail_ptr = tail_ptr + 2'd1;
        end
    endtask

    task automatic check_reset(output int errs);
        snake_pkg::segment_t exp_seg;
        errs = 0;
        if (tick !== 1'b0) begin
            $display("MISMATCH reset tick: expected 0, actual %h", tick);
            errs++;
        end
        if (mode !== m_idle || all_black !== 1'b0) begin
            $display("MISMATCH reset mode/all_black: expected %h/0, actual %h/%h",
                     m_idle, mode, all_black);
            errs++;
        end
        for (int i = 0; i < `SNAKE_LEN; i++) begin
            exp_seg.x = snake_pkg::coord_t'(i);
            exp_seg.y = snake_pkg::coord_t'(`IDLE_ROW);
            if (body[i] !== exp_seg) begin
                $display("MISMATCH reset body[%0d]: expected %h, actual %h", i, exp_seg, body[i]);
                errs++;
            end
        end
    endtask

    task automatic check_row(input int r, input row_t e, output int errs);
        snake_pkg::segment_t head_seg;
        snake_pkg::segment_t tail_seg;
        errs     = 0;
        head_seg = body[head_ptr];
        tail_seg = body[tail_ptr];
        if (mode !== e.mode) begin
            $display("MISMATCH row %0d mode: expected %h, actual %h", r, e.mode, mode);
            errs++;
        end
        if (all_black !== e.all_black) begin
            $display("MISMATCH row %0d all_black: expected %h, actual %h", r, e.all_black, all_black);
            errs++;
        end
        if (head_seg.x !== e.head_x || head_seg.y !== e.head_y) begin
            $display("MISMATCH row %0d head x/y: expected %h/%h, actual %h/%h",
                     r, e.head_x, e.head_y, head_seg.x, head_seg.y);
            errs++;
        end
        if (tail_seg.x !== e.tail_x || tail_seg.y !== e.tail_y) begin
            $display("MISMATCH row %0d tail x/y: expected %h/%h, actual %h/%h",
                     r, e.tail_x, e.tail_y, tail_seg.x, tail_seg.y);
            errs++;
        end
    endtask

    initial begin
        int errs;
        bit ok;
        main_clk  = 1'b0;
        rst_n     = 1'b0;
        key_code  = 8'h00;
        key_valid = 1'b0;
        seed      = 32'h958e_fd85;
        pass_cnt  = 0;
        fail_cnt  = 0;
        head_ptr  = snake_pkg::seg_idx_t'(`SNAKE_LEN - 1);
        tail_ptr  = '0;
        ok        = 1'b1;
        fill_table();
        repeat (8) @(negedge main_clk);
        rst_n = 1'b1;
        check_reset(errs);
        if (errs == 0) begin
            $display("reset: ok");
            pass_cnt++;
        end else begin
            $display("reset: %0d wrong values", errs);
            fail_cnt++;
        end
        for (int r = 0; r < num_rows && ok; r++) begin
            send_filler();
            if (tbl[r].key0 != 8'h00) begin
                send_key(tbl[r].key0);
                send_filler();
            end
            if (tbl[r].key1 != 8'h00) begin
                send_key(tbl[r].key1);
                send_filler();
            end
            for (int t = 0; t < tbl[r].ticks && ok; t++) begin
                if (t > 0) begin
                    send_filler(); // junk between ticks
                end
                wait_tick(ok);
            end
            if (!ok) begin
                $display("row %0d: game tick never arrived within %0d cycles", r, tick_timeout);
                fail_cnt++;
            end else begin
                track_ptrs(tbl[r]);
                check_row(r, tbl[r], errs);
                if (errs == 0) begin
                    $display("row %0d: ok", r);
                    pass_cnt++;
                end else begin
                    $display("row %0d: %0d wrong values", r, errs);
                    fail_cnt++;
                end
            end
        end
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: snake_game_top.f
+incdir+common
common/snake_pkg.sv
design/game_tick_gen.sv
design/key_decoder.sv
game_fsm/game_fsm.sv
snake_body/snake_body.sv
design/snake_game_top.sv
tests/snake_game_tb.sv
